/* dv/tcdm_sva.sv */
/*
 * Protocol assertions for the TCDM interconnect and their bind.
 */
module tcdm_sva (
    input logic                                                        clk_i,
    input logic                                                        arst_n_i,
    input logic [tcdm_cfg_pkg::NumIn-1:0]                              req_i,
    input logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::AddrWidth-1:0] add_i,
    input logic [tcdm_cfg_pkg::NumIn-1:0]                              wen_i,
    input logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0] wdata_i,
    input logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::BeWidth-1:0]   be_i,
    input logic [tcdm_cfg_pkg::NumIn-1:0]                              gnt_i,
    input logic [tcdm_cfg_pkg::NumIn-1:0]                              vld_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import tcdm_cfg_pkg::*;
    import bank_cfg_pkg::*;

    // A grant only goes to a requestor that asks.
    a_gnt_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (gnt_i & ~req_i) == '0)
        else $error("Grant without a request.");

    // Response valid comes exactly RespLat cycles after each grant and never otherwise.
    a_vld_lat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        vld_i == $past(gnt_i, RespLat))
        else $error("Response valid does not follow the grant.");

    // At most one of the requestors that address a bank sees a grant.
    for (genvar j = 0; j < NumOut; j++) begin : g_bank
        logic [NumIn-1:0] tgt;

        for (genvar i = 0; i < NumIn; i++) begin : g_tgt
            assign tgt[i] = (add_i[i][ByteOffWidth +: BankSelWidth] == BankSelWidth'(j));
        end

        a_one_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            $onehot0(gnt_i & tgt))
            else $error("Several grants on bank %0d.", j);
    end

    // A waiting requestor keeps all its fields.
    for (genvar i = 0; i < NumIn; i++) begin : g_port
        a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            req_i[i] && !gnt_i[i] |=> req_i[i] && $stable(add_i[i]) && $stable(wen_i[i])
                && $stable(wdata_i[i]) && $stable(be_i[i]))
            else $error("Request on port %0d changed before its grant.", i);
    end

endmodule : tcdm_sva

bind tcdm_interconnect tcdm_sva i_sva (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (req_i),
    .add_i      (add_i),
    .wen_i      (wen_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .gnt_i      (gnt_o),
    .vld_i      (vld_o)
);

/* dv/tcdm_tb.sv */
/*
 * Testbench for the TCDM subsystem.
 * LFSR stimulus, byte-wise memory model, round-robin model and response checks.
 */
module tcdm_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import tcdm_cfg_pkg::*;
    import bank_cfg_pkg::*;

    localparam int unsigned Words = NumOut * BankWords;
    localparam int unsigned WordBits = AddrWidth - ByteOffWidth;
    localparam logic [31:0] LfsrSeed = 32'h6caa;
    // Taps of x^32 + x^22 + x^2 + x + 1.
    localparam logic [31:0] LfsrPoly = 32'h8020_0003;
    localparam int unsigned RandCycles = 3000;
    localparam int unsigned PhaseCycles = 300;
    localparam int unsigned DrainLimit = 50;

    // Stimulus modes.
    localparam int ModeIdle = 0;
    localparam int ModeSweep = 1;
    localparam int ModeRand = 2;
    localparam int ModeSame = 3;
    localparam int ModeSpread = 4;
    localparam int ModeB2b = 5;

    logic                                clk;
    logic                                arst_n;
    logic [NumIn-1:0]                    req;
    logic [NumIn-1:0][FullAddrWidth-1:0] addr;
    logic [NumIn-1:0]                    we;
    logic [NumIn-1:0][DataWidth-1:0]     wdata;
    logic [NumIn-1:0][BeWidth-1:0]       be;
    logic [NumIn-1:0]                    gnt;
    logic [NumIn-1:0]                    rvalid;
    logic [NumIn-1:0][DataWidth-1:0]     rdata;

    // Model memory with one entry per byte.
    logic [7:0]           mem_m [Words*BeWidth];
    // Round-robin pointer per bank.
    int unsigned          ptr_m [NumOut];
    // Grants seen before the coming edge.
    logic [NumIn-1:0]     took;
    // Responses due one cycle after the grant.
    logic [NumIn-1:0]     pend_vld;
    logic [NumIn-1:0]     pend_rd;
    logic [DataWidth-1:0] pend_data [NumIn];
    int unsigned          wait_cnt [NumIn];
    int unsigned          sweep_k [NumIn];
    int                   mode;
    logic [31:0]          lfsr;
    int unsigned          spread_base;
    int unsigned          spread_rot;
    bit                   spread_all;

    always #50 clk = ~clk;

    tcdm_subsystem_top dut (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .req_i    (req),
        .addr_i   (addr),
        .we_i     (we),
        .wdata_i  (wdata),
        .be_i     (be),
        .gnt_o    (gnt),
        .rvalid_o (rvalid),
        .rdata_o  (rdata)
    );

    // One Galois step.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? LfsrPoly : 32'h0);
    endfunction

    // Returns n random bits with one LFSR step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [DataWidth-1:0] model_word(input int unsigned w);
        logic [DataWidth-1:0] v;
        for (int b = 0; b < BeWidth; b++) begin
            v[b*8 +: 8] = mem_m[w*BeWidth + b];
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run("A checked value did not match the model.");
        end
    endtask

    // Picks the next request of one port for the current mode.
    task automatic new_request(input int i);
        logic [31:0]              w;
        logic [FullAddrWidth-1:0] a;
        bit                       go;
        go = 1'b1;
        w = rand_bits(WordBits);
        case (mode)
            ModeSweep: begin
                go = sweep_k[i] < BankWords;
                w = sweep_k[i] * NumIn + i;
            end
            ModeRand: go = rand_bits(2) != 0;
            // Random word index in bank 0 for every port.
            ModeSame: w = rand_bits(AddrMemWidth) * NumOut;
            // Same word index with each port on its own bank.
            ModeSpread: w = spread_base * NumOut + (i + spread_rot) % NumOut;
            ModeB2b: go = (i == 0);
            default: go = 1'b0;
        endcase
        if (!go) begin
            req[i] <= 1'b0;
        end else begin
            // The DUT ignores the random upper bits and byte offset.
            a = rand_bits(FullAddrWidth);
            a[ByteOffWidth +: WordBits] = w[WordBits-1:0];
            req[i]   <= 1'b1;
            addr[i]  <= a;
            wdata[i] <= rand_bits(DataWidth);
            if (mode == ModeSweep) begin
                we[i] <= 1'b1;
                be[i] <= '1;
                sweep_k[i]++;
            end else begin
                we[i] <= (mode == ModeSpread) ? 1'b0 : 1'(rand_bits(1));
                be[i] <= BeWidth'(rand_bits(BeWidth));
            end
        end
    endtask

    // On the rising edge a port gets a new request once its last one was granted.
    task automatic drive_cycle();
        spread_base = rand_bits(AddrMemWidth);
        spread_rot = rand_bits(InIdxWidth);
        spread_all = (mode == ModeSpread) && (&(took | ~req));
        for (int i = 0; i < NumIn; i++) begin
            if (took[i] || !req[i]) begin
                new_request(i);
            end
        end
    endtask

    // Outputs are stable at the falling edge.
    task automatic observe_cycle();
        logic [NumIn-1:0] exp_gnt;
        logic [NumIn-1:0] hit;
        int unsigned      p;
        int unsigned      win;
        int unsigned      w;
        bit               found;
        exp_gnt = '0;
        check_eq(32'(rvalid), 32'(pend_vld), "rvalid vector");
        for (int i = 0; i < NumIn; i++) begin
            if (pend_rd[i]) begin
                check_eq(rdata[i], pend_data[i], $sformatf("read data on port %0d", i));
            end
        end
        // Requests on distinct banks are all granted together.
        if (spread_all) begin
            check_eq(32'(gnt), 32'({NumIn{1'b1}}), "grants on distinct banks");
        end
        // Scan each bank from its pointer and wrap around.
        for (int b = 0; b < NumOut; b++) begin
            found = 1'b0;
            win = 0;
            for (int i = 0; i < NumIn; i++) begin
                hit[i] = req[i] && (int'(addr[i][ByteOffWidth +: BankSelWidth]) == b);
            end
            for (int k = 0; k < NumIn; k++) begin
                p = (ptr_m[b] + k) % NumIn;
                if (!found && hit[p]) begin
                    found = 1'b1;
                    win = p;
                end
            end
            if (found) begin
                exp_gnt[win] = 1'b1;
                ptr_m[b] = (win + 1) % NumIn;
            end
        end
        check_eq(32'(gnt), 32'(exp_gnt), "grant vector");
        for (int i = 0; i < NumIn; i++) begin
            pend_rd[i] = 1'b0;
            if (exp_gnt[i]) begin
                // Granted words sit in distinct banks so reads see earlier writes only.
                w = addr[i][ByteOffWidth +: WordBits];
                pend_rd[i] = !we[i];
                pend_data[i] = model_word(w);
                for (int b = 0; b < BeWidth; b++) begin
                    if (we[i] && be[i][b]) begin
                        mem_m[w*BeWidth + b] = wdata[i][b*8 +: 8];
                    end
                end
                wait_cnt[i] = 0;
            end else if (req[i]) begin
                wait_cnt[i]++;
                if (wait_cnt[i] >= NumIn) begin
                    abort_run($sformatf("Port %0d was not granted within %0d cycles.", i, NumIn));
                end
            end
        end
        pend_vld = exp_gnt;
        took = exp_gnt;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        drive_cycle();
        @(negedge clk);
        observe_cycle();
    endtask

    task automatic run_phase(input int m, input int unsigned cycles);
        mode = m;
        for (int unsigned c = 0; c < cycles; c++) begin
            step_cycle();
        end
    endtask

    // Runs until no request and no response is left.
    task automatic drain(input int m, input int unsigned limit);
        int unsigned n;
        mode = m;
        n = 0;
        do begin
            step_cycle();
            n++;
            if (n > limit) begin
                abort_run("Timeout while waiting for the traffic to finish.");
            end
        end while (req != '0 || pend_vld != '0);
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        req = '0;
        addr = '0;
        we = '0;
        wdata = '0;
        be = '0;
        lfsr = LfsrSeed;
        mode = ModeIdle;
        took = '0;
        pend_vld = '0;
        pend_rd = '0;
        spread_all = 1'b0;
        for (int i = 0; i < NumIn; i++) begin
            wait_cnt[i] = 0;
            sweep_k[i] = 0;
            pend_data[i] = '0;
        end
        for (int b = 0; b < NumOut; b++) begin
            ptr_m[b] = 0;
        end
        // Outputs stay quiet through reset.
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            check_eq(32'(gnt), 32'h0, "grant in reset");
            check_eq(32'(rvalid), 32'h0, "rvalid in reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        run_phase(ModeIdle, 2);
        drain(ModeSweep, BankWords + 8);
        run_phase(ModeRand, RandCycles);
        run_phase(ModeSame, PhaseCycles);
        run_phase(ModeSpread, PhaseCycles);
        run_phase(ModeB2b, PhaseCycles);
        drain(ModeIdle, DrainLimit);
        $display("Test OK");
        $finish;
    end

endmodule : tcdm_tb

/* rtl/bank_cfg_pkg.sv */
/*
 * Depth and access timing of one SRAM bank.
 */
package bank_cfg_pkg;

    // Words per bank, one per word index value.
    localparam int unsigned BankWords = 64;

    // Cycles from the grant edge to response valid.
    // Matches the registered read of the bank.
    localparam int unsigned RespLat = 1;

endpackage : bank_cfg_pkg

/* rtl/tcdm_cfg_pkg.sv */
/*
 * Geometry of the TCDM interconnect and layout of the routed byte address.
 * Routed address: word index, then bank select, then byte offset.
 */
package tcdm_cfg_pkg;

    // Requestor ports and memory banks.
    localparam int unsigned NumIn = 4;
    localparam int unsigned NumOut = 4;

    // Requestor byte address as seen by the cores.
    localparam int unsigned FullAddrWidth = 32;
    // Part of the address that the interconnect routes on.
    localparam int unsigned AddrWidth = 10;

    // Word and byte enable widths.
    localparam int unsigned DataWidth = 32;
    localparam int unsigned BeWidth = DataWidth / 8;

    // Byte offset inside a word.
    localparam int unsigned ByteOffWidth = $clog2(BeWidth);
    // Bank select sits right above the byte offset, so words interleave.
    localparam int unsigned BankSelWidth = $clog2(NumOut);
    // Word index inside one bank, the rest of the routed address.
    localparam int unsigned AddrMemWidth = AddrWidth - BankSelWidth - ByteOffWidth;

    // Width of a requestor index.
    localparam int unsigned InIdxWidth = $clog2(NumIn);

endpackage : tcdm_cfg_pkg

/* rtl/tcdm_interconnect.sv */
/*
 * Logarithmic TCDM interconnect.
 * Bank decode, one round-robin arbiter per bank, request muxing
 * and a fixed latency response path back to the granted requestor.
 */
module tcdm_interconnect (
    input  logic                                                          clk_i,
    input  logic                                                          arst_n_i,
    // Requestor side.
    input  logic [tcdm_cfg_pkg::NumIn-1:0]                                req_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::AddrWidth-1:0]   add_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0]                                wen_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0]   wdata_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::BeWidth-1:0]     be_i,
    output logic [tcdm_cfg_pkg::NumIn-1:0]                                gnt_o,
    output logic [tcdm_cfg_pkg::NumIn-1:0]                                vld_o,
    output logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0]   rdata_o,
    // Bank side.
    output logic [tcdm_cfg_pkg::NumOut-1:0]                               req_o,
    output logic [tcdm_cfg_pkg::NumOut-1:0][tcdm_cfg_pkg::AddrMemWidth-1:0] add_o,
    output logic [tcdm_cfg_pkg::NumOut-1:0]                               wen_o,
    output logic [tcdm_cfg_pkg::NumOut-1:0][tcdm_cfg_pkg::DataWidth-1:0]  wdata_o,
    output logic [tcdm_cfg_pkg::NumOut-1:0][tcdm_cfg_pkg::BeWidth-1:0]    be_o,
    input  logic [tcdm_cfg_pkg::NumOut-1:0][tcdm_cfg_pkg::DataWidth-1:0]  rdata_i
);

    import tcdm_cfg_pkg::*;
    import bank_cfg_pkg::*;

    // Address fields per requestor.
    logic [NumIn-1:0][BankSelWidth-1:0]        bank_sel;
    logic [NumIn-1:0][AddrMemWidth-1:0]        word_idx;
    // Request vector and arbitration result per bank.
    logic [NumOut-1:0][NumIn-1:0]              bank_req;
    logic [NumOut-1:0][NumIn-1:0]              bank_gnt;
    logic [NumOut-1:0][InIdxWidth-1:0]         bank_idx;
    // Response pipeline, valid bit and winner index per bank.
    logic [RespLat-1:0][NumOut-1:0]            vld_q;
    logic [RespLat-1:0][NumOut-1:0][InIdxWidth-1:0] idx_q;

    for (genvar i = 0; i < NumIn; i++) begin : g_dec
        assign bank_sel[i] = add_i[i][ByteOffWidth +: BankSelWidth];
        assign word_idx[i] = add_i[i][ByteOffWidth + BankSelWidth +: AddrMemWidth];
    end

    for (genvar j = 0; j < NumOut; j++) begin : g_bank
        // Requestors that target this bank.
        for (genvar i = 0; i < NumIn; i++) begin : g_req
            assign bank_req[j][i] = req_i[i] && (bank_sel[i] == BankSelWidth'(j));
        end

        tcdm_rr_arbiter i_arbiter (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (bank_req[j]),
            .gnt_o    (bank_gnt[j]),
            .idx_o    (bank_idx[j])
        );

        // Winner fields go to the bank.
        assign req_o[j]   = |bank_req[j];
        assign add_o[j]   = word_idx[bank_idx[j]];
        assign wen_o[j]   = wen_i[bank_idx[j]];
        assign wdata_o[j] = wdata_i[bank_idx[j]];
        assign be_o[j]    = be_i[bank_idx[j]];
    end

    // A requestor targets one bank, so at most one grant reaches it.
    always_comb begin
        gnt_o = '0;
        for (int j = 0; j < NumOut; j++) begin
            gnt_o = gnt_o | bank_gnt[j];
        end
    end

    // Valid bits of the response pipeline.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= req_o;
            for (int s = 1; s < RespLat; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    // Winner index travels alongside, qualified by the valid bit.
    always_ff @(posedge clk_i) begin
        idx_q[0] <= bank_idx;
        for (int s = 1; s < RespLat; s++) begin
            idx_q[s] <= idx_q[s-1];
        end
    end

    // Steer bank read data back to the requestor that won.
    always_comb begin
        vld_o   = '0;
        rdata_o = '0;
        for (int j = 0; j < NumOut; j++) begin
            if (vld_q[RespLat-1][j]) begin
                vld_o[idx_q[RespLat-1][j]]   = 1'b1;
                rdata_o[idx_q[RespLat-1][j]] = rdata_i[j];
            end
        end
    end

endmodule : tcdm_interconnect

/* rtl/tcdm_interconnect_wrap.sv */
/*
 * Wrapper around the TCDM interconnect.
 * Trims requestor addresses, bypasses the interconnect for one requestor
 * and one bank, and rejects one requestor with several banks.
 */
module tcdm_interconnect_wrap (
    input  logic                                                              clk_i,
    input  logic                                                              arst_n_i,
    // Requestor side.
    input  logic [tcdm_cfg_pkg::NumIn-1:0]                                    req_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::FullAddrWidth-1:0]   addr_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0]                                    we_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0]       wdata_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::BeWidth-1:0]         be_i,
    output logic [tcdm_cfg_pkg::NumIn-1:0]                                    gnt_o,
    output logic [tcdm_cfg_pkg::NumIn-1:0]                                    rvalid_o,
    output logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0]       rdata_o,
    // Bank side.
    output logic [tcdm_cfg_pkg::NumOut-1:0]                                   req_o,
    output logic [tcdm_cfg_pkg::NumOut-1:0][tcdm_cfg_pkg::AddrMemWidth-1:0]   add_o,
    output logic [tcdm_cfg_pkg::NumOut-1:0]                                   wen_o,
    output logic [tcdm_cfg_pkg::NumOut-1:0][tcdm_cfg_pkg::DataWidth-1:0]      wdata_o,
    output logic [tcdm_cfg_pkg::NumOut-1:0][tcdm_cfg_pkg::BeWidth-1:0]        be_o,
    input  logic [tcdm_cfg_pkg::NumOut-1:0][tcdm_cfg_pkg::DataWidth-1:0]      rdata_i
);

    import tcdm_cfg_pkg::*;

    // Only the low bits matter for routing.
    logic [NumIn-1:0][AddrWidth-1:0] addr_trunc;

    for (genvar i = 0; i < NumIn; i++) begin : g_trunc
        assign addr_trunc[i] = addr_i[i][AddrWidth-1:0];
    end

    if (NumIn == 1 && NumOut == 1) begin : g_direct
        // Single bank, no select field and nothing to arbitrate.
        logic rvalid_q;

        assign req_o[0]   = req_i[0];
        assign add_o[0]   = addr_trunc[0][ByteOffWidth +: AddrMemWidth];
        assign wen_o[0]   = we_i[0];
        assign wdata_o[0] = wdata_i[0];
        assign be_o[0]    = be_i[0];
        assign gnt_o[0]   = 1'b1;

        // Bank answers one cycle after the request.
        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                rvalid_q <= 1'b0;
            end else begin
                rvalid_q <= req_i[0];
            end
        end

        assign rvalid_o[0] = rvalid_q;
        assign rdata_o[0]  = rdata_i[0];
    end else if (NumIn == 1) begin : g_bad_shape
        $error("tcdm_interconnect_wrap: one requestor with several banks is not supported.");
    end else begin : g_lic
        tcdm_interconnect i_tcdm_interconnect (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (req_i),
            .add_i    (addr_trunc),
            .wen_i    (we_i),
            .wdata_i  (wdata_i),
            .be_i     (be_i),
            .gnt_o    (gnt_o),
            .vld_o    (rvalid_o),
            .rdata_o  (rdata_o),
            .req_o    (req_o),
            .add_o    (add_o),
            .wen_o    (wen_o),
            .wdata_o  (wdata_o),
            .be_o     (be_o),
            .rdata_i  (rdata_i)
        );
    end

endmodule : tcdm_interconnect_wrap

/* rtl/tcdm_rr_arbiter.sv */
/*
 * Round-robin arbiter for one bank.
 * Combinational grant, priority pointer moves past the winner.
 */
module tcdm_rr_arbiter (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0]      req_i,
    output logic [tcdm_cfg_pkg::NumIn-1:0]      gnt_o,
    output logic [tcdm_cfg_pkg::InIdxWidth-1:0] idx_o
);

    import tcdm_cfg_pkg::*;

    // Requestor with the highest priority this cycle.
    logic [InIdxWidth-1:0] ptr_q;
    // One past the current winner.
    logic [InIdxWidth-1:0] nxt_ptr;
    // Set once a requestor has been picked in the scan.
    logic                  found;

    // Scan from the pointer upwards and wrap around.
    always_comb begin
        gnt_o = '0;
        idx_o = ptr_q;
        found = 1'b0;
        for (int off = 0; off < NumIn; off++) begin
            if (!found && req_i[(int'(ptr_q) + off) % NumIn]) begin
                found = 1'b1;
                idx_o = InIdxWidth'((int'(ptr_q) + off) % NumIn);
            end
        end
        // Only one grant bit, the winner.
        if (found) begin
            gnt_o[idx_o] = 1'b1;
        end
    end

    assign nxt_ptr = InIdxWidth'((int'(idx_o) + 1) % NumIn);

    // The bank takes every request, so any request is a grant.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (|req_i) begin
            ptr_q <= nxt_ptr;
        end
    end

endmodule : tcdm_rr_arbiter

/* rtl/tcdm_sram_bank.sv */
/*
 * One SRAM bank of the TCDM.
 * Byte-enabled writes, registered reads with one cycle of latency.
 */
module tcdm_sram_bank #(
    parameter int unsigned Words = bank_cfg_pkg::BankWords
) (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    input  logic                                  req_i,
    input  logic                                  we_i,
    input  logic [tcdm_cfg_pkg::AddrMemWidth-1:0] addr_i,
    input  logic [tcdm_cfg_pkg::DataWidth-1:0]    wdata_i,
    input  logic [tcdm_cfg_pkg::BeWidth-1:0]      be_i,
    output logic [tcdm_cfg_pkg::DataWidth-1:0]    rdata_o
);

    import tcdm_cfg_pkg::*;

    // Storage array.
    logic [DataWidth-1:0] mem_q [Words];

    // Write only the bytes with their enable set.
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int b = 0; b < BeWidth; b++) begin
                if (be_i[b]) begin
                    mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Read returns the contents from before this edge.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else if (req_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule : tcdm_sram_bank

/* rtl/tcdm_subsystem_top.sv */
/*
 * TCDM subsystem top level.
 * Interconnect wrapper plus one SRAM bank per output port.
 */
module tcdm_subsystem_top (
    input  logic                                                            clk_i,
    input  logic                                                            arst_n_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0]                                  req_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::FullAddrWidth-1:0] addr_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0]                                  we_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0]     wdata_i,
    input  logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::BeWidth-1:0]       be_i,
    output logic [tcdm_cfg_pkg::NumIn-1:0]                                  gnt_o,
    output logic [tcdm_cfg_pkg::NumIn-1:0]                                  rvalid_o,
    output logic [tcdm_cfg_pkg::NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0]     rdata_o
);

    import tcdm_cfg_pkg::*;
    import bank_cfg_pkg::*;

    // Bank side wires.
    logic [NumOut-1:0]                   bank_req;
    logic [NumOut-1:0][AddrMemWidth-1:0] bank_addr;
    logic [NumOut-1:0]                   bank_we;
    logic [NumOut-1:0][DataWidth-1:0]    bank_wdata;
    logic [NumOut-1:0][BeWidth-1:0]      bank_be;
    logic [NumOut-1:0][DataWidth-1:0]    bank_rdata;

    tcdm_interconnect_wrap i_wrap (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .addr_i   (addr_i),
        .we_i     (we_i),
        .wdata_i  (wdata_i),
        .be_i     (be_i),
        .gnt_o    (gnt_o),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o),
        .req_o    (bank_req),
        .add_o    (bank_addr),
        .wen_o    (bank_we),
        .wdata_o  (bank_wdata),
        .be_o     (bank_be),
        .rdata_i  (bank_rdata)
    );

    // Word-interleaved banks.
    for (genvar j = 0; j < NumOut; j++) begin : g_bank
        tcdm_sram_bank #(
            .Words (BankWords)
        ) i_bank (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (bank_req[j]),
            .we_i     (bank_we[j]),
            .addr_i   (bank_addr[j]),
            .wdata_i  (bank_wdata[j]),
            .be_i     (bank_be[j]),
            .rdata_o  (bank_rdata[j])
        );
    end

endmodule : tcdm_subsystem_top

/* run.sh */
#!/bin/sh
# Compiles the TCDM testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tcdm_tb -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed."
    exit 1
fi

out=$(./obj_dir/Vtcdm_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
echo "Pass message not found in the simulation output."
exit 1

/* tb.f */
rtl/tcdm_cfg_pkg.sv
rtl/bank_cfg_pkg.sv
rtl/tcdm_rr_arbiter.sv
rtl/tcdm_interconnect.sv
rtl/tcdm_interconnect_wrap.sv
rtl/tcdm_sram_bank.sv
rtl/tcdm_subsystem_top.sv
dv/tcdm_sva.sv
dv/tcdm_tb.sv
